/* project.f */
logic/cdc_pkg.sv
logic/axis_pkg.sv
logic/axis_skid_register.sv
logic/axis_async_fifo.sv
logic/axis_frame_monitor.sv
logic/axis_cdc_path.sv
tests/axis_cdc_checker.sv
tests/tb_axis_cdc_path.sv

/* Bender.yml */
package:
  name: axis_cdc_path

sources:
  - logic/cdc_pkg.sv
  - logic/axis_pkg.sv
  - logic/axis_skid_register.sv
  - logic/axis_async_fifo.sv
  - logic/axis_frame_monitor.sv
  - logic/axis_cdc_path.sv
  - target: test
    files:
      - tests/axis_cdc_checker.sv
      - tests/tb_axis_cdc_path.sv

/* tests/tb_axis_cdc_path.sv */
`timescale 1ns/1ps

module tb_axis_cdc_path import cdc_pkg::*, axis_pkg::*;;

  localparam int DATA_WIDTH = AXIS_DATA_WIDTH;
  localparam int MAX_LEN    = 6;
  localparam int RAND_FRAMES = 20;
  localparam int LONG_FRAME  = 30;
  // two random tests plus the long frame, every frame at its longest
  localparam int MAX_BEATS  = 2 * RAND_FRAMES * MAX_LEN + LONG_FRAME;
  localparam int MARGIN_NS  = (SYNC_STAGES + RST_STAGES + 100) * 40;
  localparam int TIMEOUT_NS = MAX_BEATS * 40 + MARGIN_NS;

  logic                   input_clk = 1'b0;
  logic                   output_clk = 1'b0;
  logic                   output_rst_sync3;
  logic [DATA_WIDTH-1:0]  in_tdata;
  logic                   in_tvalid;
  logic                   in_tlast;
  logic                   in_tuser;
  logic                   in_tready;
  logic [DATA_WIDTH-1:0]  out_tdata;
  logic                   out_tvalid;
  logic                   out_tlast;
  logic                   out_tuser;
  logic                   out_tready;
  logic [COUNT_WIDTH-1:0] frame_count;
  logic [COUNT_WIDTH-1:0] error_count;

  logic [31:0] stim_state = 32'hb35;
  logic [31:0] ready_state = 32'hb35;
  int          ready_mode = 0; // 0 always ready, 1 random, 2 stalled

  always #4 output_clk = ~output_clk;
  always #5 input_clk = ~input_clk;

  axis_cdc_path #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(FIFO_ADDR_WIDTH)
  ) axis_cdc_path_i (.*);

  axis_cdc_checker #(.DATA_WIDTH(DATA_WIDTH)) checker_i (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  always @(posedge output_clk) begin
    ready_state = lcg_next(ready_state);
    case (ready_mode)
      0: out_tready <= 1'b1;
      1: out_tready <= ready_state[16];
      default: out_tready <= 1'b0;
    endcase
  end

  task automatic send_frame(input int len, input int stall_pct);
    for (int i = 0; i < len; i++) begin
      stim_state = lcg_next(stim_state);
      if (stim_state[23:16] % 100 < stall_pct) begin
        in_tvalid <= 1'b0; // idle gap
        @(posedge input_clk);
      end
      stim_state = lcg_next(stim_state);
      in_tdata  <= DATA_WIDTH'(stim_state >> 8);
      in_tuser  <= stim_state[27];
      in_tlast  <= (i == len - 1);
      in_tvalid <= 1'b1;
      @(posedge input_clk);
      while (!in_tready) @(posedge input_clk);
    end
    in_tvalid <= 1'b0;
  endtask

  task automatic random_frames(input int stall_pct);
    int len;
    for (int f = 0; f < RAND_FRAMES; f++) begin
      stim_state = lcg_next(stim_state);
      len = 1 + stim_state[20:16] % MAX_LEN;
      send_frame(len, stall_pct);
    end
  endtask

  initial begin
    #(TIMEOUT_NS * 1ns);
    $display("timeout after %0d ns, the stream stopped moving", TIMEOUT_NS);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int waited;
    output_rst_sync3 = 1'b1;
    in_tdata  = '0;
    in_tvalid = 1'b0;
    in_tlast  = 1'b0;
    in_tuser  = 1'b0;
    out_tready = 1'b1;
    repeat (2) @(posedge output_clk);
    output_rst_sync3 <= 1'b0;

    checker_i.start_test("reset");
    @(posedge output_clk);
    checker_i.check_idle();
    waited = 0;
    @(posedge input_clk);
    while (!in_tready && waited < 20) begin
      @(posedge input_clk);
      waited++;
    end
    if (!in_tready) checker_i.note_failure("in_tready stayed low after reset release");
    checker_i.end_test();

    checker_i.start_test("in_order");
    @(posedge input_clk);
    random_frames(20);
    checker_i.end_test();

    checker_i.start_test("backpressure");
    @(posedge input_clk);
    ready_mode = 1;
    random_frames(10);
    checker_i.end_test();

    checker_i.start_test("fill");
    @(posedge input_clk);
    ready_mode = 2;
    fork
      send_frame(LONG_FRAME, 0);
      begin
        waited = 0;
        while (in_tready && waited < 4 * FIFO_DEPTH) begin
          @(posedge input_clk);
          waited++;
        end
        checker_i.check_fill(FIFO_DEPTH);
        ready_mode = 0;
      end
    join
    checker_i.end_test();

    $display("%0d tests, %0d failed, %0d errors", checker_i.test_total,
             checker_i.fail_total, checker_i.error_total);
    if (checker_i.error_total == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* tests/axis_cdc_checker.sv */
`timescale 1ns/1ps

module axis_cdc_checker import axis_pkg::*; #(
  parameter int DATA_WIDTH = AXIS_DATA_WIDTH
) (
  input logic                   input_clk,
  input logic                   output_clk,
  input logic                   output_rst_sync3,
  input logic [DATA_WIDTH-1:0]  in_tdata,
  input logic                   in_tvalid,
  input logic                   in_tlast,
  input logic                   in_tuser,
  input logic                   in_tready,
  input logic [DATA_WIDTH-1:0]  out_tdata,
  input logic                   out_tvalid,
  input logic                   out_tlast,
  input logic                   out_tuser,
  input logic                   out_tready,
  input logic [COUNT_WIDTH-1:0] frame_count,
  input logic [COUNT_WIDTH-1:0] error_count
);

  logic [DATA_WIDTH+1:0] exp_q[$];   // {tlast, tuser, tdata}
  logic [DATA_WIDTH+1:0] history[$]; // every accepted beat
  logic [DATA_WIDTH+1:0] prev_beat;
  logic                  prev_stall = 1'b0;
  string test_name = "none";
  int    test_errors = 0;
  int    accepted_in_test = 0;
  int    error_total = 0;
  int    fail_total = 0;
  int    test_total = 0;

  // expected counter value over all accepted beats, wraps like the hardware
  function automatic logic [COUNT_WIDTH-1:0] expected_count(input bit errors_only);
    logic [COUNT_WIDTH-1:0] n = '0;
    foreach (history[i]) begin
      if (history[i][DATA_WIDTH+1] && (!errors_only || history[i][DATA_WIDTH])) n++;
    end
    return n;
  endfunction

  task automatic report(input string what, input logic [31:0] exp, input logic [31:0] act);
    $display("** Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
    test_errors++;
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errors = 0;
    accepted_in_test = 0;
  endtask

  task automatic check_idle();
    if (out_tvalid !== 1'b0) report("out_tvalid", 0, out_tvalid);
    if (frame_count !== '0) report("frame_count", 0, frame_count);
    if (error_count !== '0) report("error_count", 0, error_count);
  endtask

  // memory, FIFO output register and both skid slots
  task automatic check_fill(input int depth);
    if (in_tready) note_failure("in_tready still high with the output stalled");
    if (accepted_in_test > depth + 3 || accepted_in_test < depth)
      report("accepted beats", depth + 3, accepted_in_test);
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) @(posedge output_clk);
    repeat (2) @(posedge output_clk);
    if (frame_count !== expected_count(0)) report("frame_count", expected_count(0), frame_count);
    if (error_count !== expected_count(1)) report("error_count", expected_count(1), error_count);
    test_total++;
    if (test_errors != 0) fail_total++;
    error_total += test_errors;
    $display("test %s: %s, %0d errors", test_name, test_errors ? "FAIL" : "ok", test_errors);
  endtask

  always @(posedge input_clk) begin
    if (in_tvalid && in_tready) begin
      exp_q.push_back({in_tlast, in_tuser, in_tdata});
      history.push_back({in_tlast, in_tuser, in_tdata});
      accepted_in_test++;
    end
  end

  always @(posedge output_clk) begin
    if (output_rst_sync3) begin
      prev_stall <= 1'b0;
    end else begin
      if (prev_stall && out_tvalid !== 1'b1)
        note_failure("out_tvalid dropped while the output was stalled");
      if (prev_stall && {out_tlast, out_tuser, out_tdata} !== prev_beat)
        report("held beat", prev_beat, {out_tlast, out_tuser, out_tdata});
      if (out_tvalid && out_tready) begin
        if (exp_q.size() == 0) note_failure("a beat came out that was never sent");
        else if ({out_tlast, out_tuser, out_tdata} !== exp_q[0])
          report("beat", exp_q.pop_front(), {out_tlast, out_tuser, out_tdata});
        else void'(exp_q.pop_front());
      end
      prev_stall <= out_tvalid && !out_tready; // outputs must hold next edge
      prev_beat  <= {out_tlast, out_tuser, out_tdata};
    end
  end

endmodule

/* logic/axis_cdc_path.sv */
`timescale 1ns/1ps

module axis_cdc_path import cdc_pkg::*, axis_pkg::*; #(
  parameter int DATA_WIDTH = AXIS_DATA_WIDTH,
  parameter int ADDR_WIDTH = FIFO_ADDR_WIDTH
) (
  input  logic                   input_clk,
  input  logic                   output_clk,
  input  logic                   output_rst_sync3,
  input  logic [DATA_WIDTH-1:0]  in_tdata,
  input  logic                   in_tvalid,
  input  logic                   in_tlast,
  input  logic                   in_tuser,
  output logic                   in_tready,
  output logic [DATA_WIDTH-1:0]  out_tdata,
  output logic                   out_tvalid,
  output logic                   out_tlast,
  output logic                   out_tuser,
  input  logic                   out_tready,
  output logic [COUNT_WIDTH-1:0] frame_count,
  output logic [COUNT_WIDTH-1:0] error_count
);

  logic                  input_rst;
  logic [DATA_WIDTH-1:0] skid_tdata;
  logic                  skid_tvalid;
  logic                  skid_tlast;
  logic                  skid_tuser;
  logic                  skid_tready;
  logic [DATA_WIDTH-1:0] fifo_tdata;
  logic                  fifo_tvalid;
  logic                  fifo_tlast;
  logic                  fifo_tuser;
  logic                  fifo_tready;

  axis_skid_register #(
    .DATA_WIDTH(DATA_WIDTH)
  ) axis_skid_register_i (
    .input_clk(input_clk),
    .input_rst(input_rst),
    .s_tdata(in_tdata),
    .s_tvalid(in_tvalid),
    .s_tlast(in_tlast),
    .s_tuser(in_tuser),
    .s_tready(in_tready),
    .m_tdata(skid_tdata),
    .m_tvalid(skid_tvalid),
    .m_tlast(skid_tlast),
    .m_tuser(skid_tuser),
    .m_tready(skid_tready)
  );

  axis_async_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .ADDR_WIDTH(ADDR_WIDTH)
  ) axis_async_fifo_i (
    .input_clk(input_clk),
    .input_rst(input_rst),
    .s_tdata(skid_tdata),
    .s_tvalid(skid_tvalid),
    .s_tlast(skid_tlast),
    .s_tuser(skid_tuser),
    .s_tready(skid_tready),
    .output_clk(output_clk),
    .output_rst_sync3(output_rst_sync3),
    .m_tdata(fifo_tdata),
    .m_tvalid(fifo_tvalid),
    .m_tlast(fifo_tlast),
    .m_tuser(fifo_tuser),
    .m_tready(fifo_tready)
  );

  axis_frame_monitor #(
    .DATA_WIDTH(DATA_WIDTH)
  ) axis_frame_monitor_i (
    .output_clk(output_clk),
    .output_rst_sync3(output_rst_sync3),
    .s_tdata(fifo_tdata),
    .s_tvalid(fifo_tvalid),
    .s_tlast(fifo_tlast),
    .s_tuser(fifo_tuser),
    .s_tready(fifo_tready),
    .m_tdata(out_tdata),
    .m_tvalid(out_tvalid),
    .m_tlast(out_tlast),
    .m_tuser(out_tuser),
    .m_tready(out_tready),
    .frame_count(frame_count),
    .error_count(error_count)
  );

endmodule

/* logic/axis_frame_monitor.sv */
`timescale 1ns/1ps

module axis_frame_monitor import axis_pkg::*; #(
  parameter int DATA_WIDTH = AXIS_DATA_WIDTH
) (
  input  logic                   output_clk,
  input  logic                   output_rst_sync3,
  input  logic [DATA_WIDTH-1:0]  s_tdata,
  input  logic                   s_tvalid,
  input  logic                   s_tlast,
  input  logic                   s_tuser,
  output logic                   s_tready,
  output logic [DATA_WIDTH-1:0]  m_tdata,
  output logic                   m_tvalid,
  output logic                   m_tlast,
  output logic                   m_tuser,
  input  logic                   m_tready,
  output logic [COUNT_WIDTH-1:0] frame_count,
  output logic [COUNT_WIDTH-1:0] error_count
);

  logic frame_end;

  // stream passes straight through, the monitor only taps it
  assign m_tdata  = s_tdata;
  assign m_tvalid = s_tvalid;
  assign m_tlast  = s_tlast;
  assign m_tuser  = s_tuser;
  assign s_tready = m_tready;

  assign frame_end = s_tvalid & m_tready & s_tlast; // last beat transferred

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      frame_count <= '0;
      error_count <= '0;
    end else if (frame_end) begin
      frame_count <= frame_count + 1'b1;
      if (s_tuser) error_count <= error_count + 1'b1; // tuser on tlast marks a bad frame
    end
  end

endmodule

/* logic/axis_async_fifo.sv */
`timescale 1ns/1ps

module axis_async_fifo import cdc_pkg::*, axis_pkg::*; #(
  parameter int DATA_WIDTH = AXIS_DATA_WIDTH,
  parameter int ADDR_WIDTH = FIFO_ADDR_WIDTH
) (
  input  logic                  input_clk,
  output logic                  input_rst,
  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic                  s_tvalid,
  input  logic                  s_tlast,
  input  logic                  s_tuser,
  output logic                  s_tready,
  input  logic                  output_clk,
  input  logic                  output_rst_sync3,
  output logic [DATA_WIDTH-1:0] m_tdata,
  output logic                  m_tvalid,
  output logic                  m_tlast,
  output logic                  m_tuser,
  input  logic                  m_tready
);

  // stored word keeps the package layout, scaled to this data width
  localparam int WORD_WIDTH = BEAT_WIDTH - AXIS_DATA_WIDTH + DATA_WIDTH;
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1; // extra wrap bit

  // top two Gray bits differ when the write side is a full lap ahead
  localparam logic [PTR_WIDTH-1:0] FULL_MASK = {2'b11, {(ADDR_WIDTH-1){1'b0}}};

  logic [WORD_WIDTH-1:0] mem [2**ADDR_WIDTH];
  logic [WORD_WIDTH-1:0] data_in;
  logic [WORD_WIDTH-1:0] data_out_reg;

  logic [RST_STAGES-1:0] rst_chain = '1;

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] wr_ptr_next;
  logic [PTR_WIDTH-1:0] wr_gray;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr_next;
  logic [PTR_WIDTH-1:0] rd_gray;

  logic [SYNC_STAGES-1:0][PTR_WIDTH-1:0] rd_gray_sync; // in input_clk
  logic [SYNC_STAGES-1:0][PTR_WIDTH-1:0] wr_gray_sync; // in output_clk

  logic full;
  logic empty;
  logic write;
  logic read;
  logic out_ready;

  assign data_in = {s_tlast, s_tuser, s_tdata};
  assign {m_tlast, m_tuser, m_tdata} = data_out_reg;

  assign full  = wr_gray == (rd_gray_sync[SYNC_STAGES-1] ^ FULL_MASK);
  assign empty = rd_gray == wr_gray_sync[SYNC_STAGES-1];

  assign s_tready  = ~full & ~input_rst;
  assign write     = s_tvalid & s_tready;
  assign out_ready = m_tready | ~m_tvalid; // output register free next edge
  assign read      = out_ready & ~empty;

  assign wr_ptr_next = wr_ptr + 1'b1;
  assign rd_ptr_next = rd_ptr + 1'b1;

  // output-side reset into input_clk; stage 2 also sees it directly so the
  // write side stays held for as long as the output side is in reset
  assign input_rst = rst_chain[RST_STAGES-1];

  always_ff @(posedge input_clk) begin
    rst_chain <= {rst_chain[RST_STAGES-2:1], rst_chain[0] | output_rst_sync3, output_rst_sync3};
  end

  always_ff @(posedge input_clk) begin
    if (input_rst) begin
      wr_ptr  <= '0;
      wr_gray <= '0;
    end else if (write) begin
      wr_ptr  <= wr_ptr_next;
      wr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
    end
  end

  always_ff @(posedge input_clk) begin
    if (write) mem[wr_ptr[ADDR_WIDTH-1:0]] <= data_in;
  end

  always_ff @(posedge input_clk) begin
    if (input_rst) rd_gray_sync <= '0;
    else rd_gray_sync <= {rd_gray_sync[SYNC_STAGES-2:0], rd_gray};
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) wr_gray_sync <= '0;
    else wr_gray_sync <= {wr_gray_sync[SYNC_STAGES-2:0], wr_gray};
  end

  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) begin
      rd_ptr  <= '0;
      rd_gray <= '0;
    end else if (read) begin
      rd_ptr  <= rd_ptr_next;
      rd_gray <= rd_ptr_next ^ (rd_ptr_next >> 1);
    end
  end

  always_ff @(posedge output_clk) begin
    if (read) data_out_reg <= mem[rd_ptr[ADDR_WIDTH-1:0]];
  end

  // refill whenever the register is empty or being taken
  always_ff @(posedge output_clk) begin
    if (output_rst_sync3) m_tvalid <= 1'b0;
    else if (out_ready) m_tvalid <= ~empty;
  end

endmodule

/* logic/axis_skid_register.sv */
`timescale 1ns/1ps

module axis_skid_register import axis_pkg::*; #(
  parameter int DATA_WIDTH = AXIS_DATA_WIDTH
) (
  input  logic                  input_clk,
  input  logic                  input_rst,
  input  logic [DATA_WIDTH-1:0] s_tdata,
  input  logic                  s_tvalid,
  input  logic                  s_tlast,
  input  logic                  s_tuser,
  output logic                  s_tready,
  output logic [DATA_WIDTH-1:0] m_tdata,
  output logic                  m_tvalid,
  output logic                  m_tlast,
  output logic                  m_tuser,
  input  logic                  m_tready
);

  logic                  s_ready_reg;
  logic                  skid_valid;
  logic [DATA_WIDTH-1:0] skid_tdata;
  logic                  skid_tlast;
  logic                  skid_tuser;
  logic                  main_load;
  logic                  ready_next;

  assign s_tready = s_ready_reg;

  // main slot takes the input when it is empty or being drained
  assign main_load = m_tready | ~m_tvalid;

  // stay ready unless the skid slot is (or is about to be) occupied
  assign ready_next = m_tready | (~skid_valid & (~m_tvalid | ~s_tvalid));

  always_ff @(posedge input_clk) begin
    if (input_rst) begin
      s_ready_reg <= 1'b0;
      m_tvalid    <= 1'b0;
      skid_valid  <= 1'b0;
    end else begin
      s_ready_reg <= ready_next;
      if (s_ready_reg) begin
        if (main_load) m_tvalid <= s_tvalid;
        else skid_valid <= s_tvalid; // downstream stalled, park the beat
      end else if (m_tready) begin
        m_tvalid   <= skid_valid; // drain the parked beat
        skid_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge input_clk) begin
    if (s_ready_reg && main_load) begin
      {m_tlast, m_tuser, m_tdata} <= {s_tlast, s_tuser, s_tdata};
    end else if (s_ready_reg) begin
      {skid_tlast, skid_tuser, skid_tdata} <= {s_tlast, s_tuser, s_tdata};
    end else if (m_tready) begin
      {m_tlast, m_tuser, m_tdata} <= {skid_tlast, skid_tuser, skid_tdata};
    end
  end

endmodule

/* logic/axis_pkg.sv */
package axis_pkg;

  // tdata width of one beat
  localparam int AXIS_DATA_WIDTH = 8;

  // stored FIFO word, {tlast, tuser, tdata} from the top down
  localparam int BEAT_WIDTH = AXIS_DATA_WIDTH + 2;
  localparam int BEAT_LAST_BIT = BEAT_WIDTH - 1;
  localparam int BEAT_USER_BIT = BEAT_WIDTH - 2;

  // frame and error counter width, both wrap
  localparam int COUNT_WIDTH = 16;

endpackage

/* logic/cdc_pkg.sv */
package cdc_pkg;

  // log2 of the number of FIFO entries
  localparam int FIFO_ADDR_WIDTH = 4;

  // flops per Gray pointer synchronizer, at least 2
  localparam int SYNC_STAGES = 2;

  // derived depth, handy for fill level arithmetic
  localparam int FIFO_DEPTH = 2 ** FIFO_ADDR_WIDTH;

  // depth of the reset chain into input_clk
  localparam int RST_STAGES = 3;

endpackage
